//--- src/rp_pkg.sv
// analog core shared definitions
package rp_pkg;

  ////////////////////////////////////////////////////////////
  // system bus
  ////////////////////////////////////////////////////////////

  localparam int BUS_AW = 32; // byte address
  localparam int BUS_DW = 32; // read and write data

  localparam int N_REGIONS  = 8;  // addr[22:20] picks one
  localparam int REGION_LSB = 20; // lowest bit of region field

  localparam int unsigned REGION_HK  = 0; // housekeeping
  localparam int unsigned REGION_ANA = 1; // analog set-points and samples

  localparam int OFS_W = 20; // offset bits seen by each block

  ////////////////////////////////////////////////////////////
  // housekeeping map, region 0
  ////////////////////////////////////////////////////////////

  localparam logic [OFS_W-1:0] HK_ID_OFS   = 20'h00; // read only
  localparam logic [OFS_W-1:0] HK_LOOP_OFS = 20'h04; // bit 0 digital loopback
  localparam logic [OFS_W-1:0] HK_LED_OFS  = 20'h08; // led byte

  localparam logic [BUS_DW-1:0] HK_ID_VALUE = 32'hA0A1_0014; // board id word

  localparam int LED_W = 8;

  ////////////////////////////////////////////////////////////
  // analog map, region 1
  ////////////////////////////////////////////////////////////

  localparam logic [OFS_W-1:0] ANA_LEVEL_A_OFS  = 20'h00;
  localparam logic [OFS_W-1:0] ANA_LEVEL_B_OFS  = 20'h04;
  localparam logic [OFS_W-1:0] ANA_OFFSET_A_OFS = 20'h08;
  localparam logic [OFS_W-1:0] ANA_OFFSET_B_OFS = 20'h0C;
  localparam logic [OFS_W-1:0] ANA_ADC_A_OFS    = 20'h10; // live sample, read only
  localparam logic [OFS_W-1:0] ANA_ADC_B_OFS    = 20'h14;

  // converter sample, two's complement
  typedef logic signed [13:0] sample_t;

endpackage

//--- src/sys_bus_decoder.sv
// system bus region decoder
module sys_bus_decoder
  import rp_pkg::*;
(
  // master side
  input  logic [BUS_AW-1:0] sys_addr_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  output logic [BUS_DW-1:0] sys_rdata_o,
  output logic              sys_err_o,
  output logic              sys_ack_o,
  // housekeeping block
  input  logic [BUS_DW-1:0] hk_rdata_i,
  input  logic              hk_ack_i,
  output logic              hk_wen_o,
  output logic              hk_ren_o,
  // analog block
  input  logic [BUS_DW-1:0] ana_rdata_i,
  input  logic              ana_ack_i,
  output logic              ana_wen_o,
  output logic              ana_ren_o
);

  localparam int REGION_W = $clog2(N_REGIONS); // 3 bits

  logic [REGION_W-1:0]  region; // addressed region
  logic [N_REGIONS-1:0] cs;     // one-hot chip select

  assign region = sys_addr_i[REGION_LSB +: REGION_W];
  assign cs     = {{(N_REGIONS-1){1'b0}}, 1'b1} << region;

  // strobes go only to the selected block
  assign hk_wen_o  = cs[REGION_HK] & sys_wen_i;
  assign hk_ren_o  = cs[REGION_HK] & sys_ren_i;
  assign ana_wen_o = cs[REGION_ANA] & sys_wen_i;
  assign ana_ren_o = cs[REGION_ANA] & sys_ren_i;

  ////////////////////////////////////////////////////////////
  // answer of the addressed region
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case (region)
      REGION_HK:
      begin
        sys_rdata_o = hk_rdata_i;
        sys_ack_o   = hk_ack_i;
      end
      REGION_ANA:
      begin
        sys_rdata_o = ana_rdata_i;
        sys_ack_o   = ana_ack_i;
      end
      default:
      begin
        sys_rdata_o = '0;   // empty regions read zero
        sys_ack_o   = 1'b1; // and always acknowledge
      end
    endcase
  end

  assign sys_err_o = 1'b0; // no region reports errors

endmodule

//--- src/housekeeping_regs.sv
// housekeeping registers
module housekeeping_regs
  import rp_pkg::*;
(
  input  logic              adc_clk,
  input  logic              arst_n_i,
  // bus slave
  input  logic [OFS_W-1:0]  addr_i,
  input  logic [BUS_DW-1:0] wdata_i,
  input  logic              wen_i,
  input  logic              ren_i,
  output logic [BUS_DW-1:0] rdata_o,
  output logic              ack_o,
  // board controls
  output logic [LED_W-1:0]  led_o,
  output logic              digital_loop_o
);

  logic [LED_W-1:0]  led_q;   // led byte
  logic              loop_q;  // adc takes dac value when set
  logic [BUS_DW-1:0] rd_mux;  // read value for current offset
  logic [BUS_DW-1:0] rdata_q;
  logic              ack_q;

  ////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      led_q  <= '0;
      loop_q <= 1'b0;
    end
    else if (wen_i)
    begin
      case (addr_i)
        HK_LOOP_OFS: loop_q <= wdata_i[0];
        HK_LED_OFS:  led_q  <= wdata_i[LED_W-1:0];
        default:     ; // id and holes ignore writes
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case (addr_i)
      HK_ID_OFS:   rd_mux = HK_ID_VALUE;
      HK_LOOP_OFS: rd_mux = {{(BUS_DW-1){1'b0}}, loop_q};
      HK_LED_OFS:  rd_mux = {{(BUS_DW-LED_W){1'b0}}, led_q};
      default:     rd_mux = '0; // undefined offsets
    endcase
  end

  // answer one cycle after the strobe
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ack_q   <= 1'b0;
      rdata_q <= '0;
    end
    else
    begin
      ack_q <= wen_i | ren_i; // writes ack too
      if (ren_i)
        rdata_q <= rd_mux;
    end
  end

  assign rdata_o        = rdata_q;
  assign ack_o          = ack_q;
  assign led_o          = led_q;
  assign digital_loop_o = loop_q;

endmodule

//--- src/analog_regs.sv
// analog set-point and sample registers
module analog_regs
  import rp_pkg::*;
(
  input  logic              adc_clk,
  input  logic              arst_n_i,
  // bus slave
  input  logic [OFS_W-1:0]  addr_i,
  input  logic [BUS_DW-1:0] wdata_i,
  input  logic              wen_i,
  input  logic              ren_i,
  output logic [BUS_DW-1:0] rdata_o,
  output logic              ack_o,
  // live samples from the adc path
  input  sample_t           adc_a_i,
  input  sample_t           adc_b_i,
  // dac set-points
  output sample_t           level_a_o,
  output sample_t           level_b_o,
  output sample_t           offset_a_o,
  output sample_t           offset_b_o
);

  localparam int SMP_W = $bits(sample_t); // 14

  sample_t level_a_q, level_b_q;   // per channel level
  sample_t offset_a_q, offset_b_q; // per channel offset
  sample_t rd_smp;                 // selected sample for read-back
  logic [BUS_DW-1:0] rdata_q;
  logic              ack_q;

  ////////////////////////////////////////////////////////////
  // set-points, low 14 bits of write data
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      level_a_q  <= '0;
      level_b_q  <= '0;
      offset_a_q <= '0;
      offset_b_q <= '0;
    end
    else if (wen_i)
    begin
      case (addr_i)
        ANA_LEVEL_A_OFS:  level_a_q  <= wdata_i[SMP_W-1:0];
        ANA_LEVEL_B_OFS:  level_b_q  <= wdata_i[SMP_W-1:0];
        ANA_OFFSET_A_OFS: offset_a_q <= wdata_i[SMP_W-1:0];
        ANA_OFFSET_B_OFS: offset_b_q <= wdata_i[SMP_W-1:0];
        default:          ; // samples are read only
      endcase
    end
  end

  // read select, every source is a signed sample
  always_comb
  begin
    case (addr_i)
      ANA_LEVEL_A_OFS:  rd_smp = level_a_q;
      ANA_LEVEL_B_OFS:  rd_smp = level_b_q;
      ANA_OFFSET_A_OFS: rd_smp = offset_a_q;
      ANA_OFFSET_B_OFS: rd_smp = offset_b_q;
      ANA_ADC_A_OFS:    rd_smp = adc_a_i;
      ANA_ADC_B_OFS:    rd_smp = adc_b_i;
      default:          rd_smp = '0; // hole reads zero
    endcase
  end

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ack_q   <= 1'b0;
      rdata_q <= '0;
    end
    else
    begin
      ack_q <= wen_i | ren_i;
      if (ren_i) // sign-extend to bus width
        rdata_q <= {{(BUS_DW-SMP_W){rd_smp[SMP_W-1]}}, rd_smp};
    end
  end

  assign rdata_o    = rdata_q;
  assign ack_o      = ack_q;
  assign level_a_o  = level_a_q;
  assign level_b_o  = level_b_q;
  assign offset_a_o = offset_a_q;
  assign offset_b_o = offset_b_q;

endmodule

//--- src/adc_frontend.sv
// adc input stage
module adc_frontend #(
  parameter int DAT_W = 14 // converter resolution
) (
  input  logic                    adc_clk,
  input  logic                    arst_n_i,
  input  logic        [DAT_W-1:0] adc_dat_a_i,    // raw code, negative slope
  input  logic        [DAT_W-1:0] adc_dat_b_i,
  input  logic                    digital_loop_i, // take dac value instead
  input  logic signed [DAT_W-1:0] loop_a_i,       // saturated dac sum
  input  logic signed [DAT_W-1:0] loop_b_i,
  output logic signed [DAT_W-1:0] adc_a_o,
  output logic signed [DAT_W-1:0] adc_b_o
);

  logic [DAT_W-1:0] dat_a_q, dat_b_q; // input register

  // offset binary with negative slope to two's complement
  // msb kept, rest inverted
  function automatic logic signed [DAT_W-1:0] ob_to_tc(input logic [DAT_W-1:0] code);
    return {code[DAT_W-1], ~code[DAT_W-2:0]};
  endfunction

  ////////////////////////////////////////////////////////////
  // capture
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dat_a_q <= '0;
      dat_b_q <= '0;
    end
    else
    begin
      dat_a_q <= adc_dat_a_i; // one edge of latency
      dat_b_q <= adc_dat_b_i;
    end
  end

  // conversion and loopback are combinational after the register
  assign adc_a_o = digital_loop_i ? loop_a_i : ob_to_tc(dat_a_q);
  assign adc_b_o = digital_loop_i ? loop_b_i : ob_to_tc(dat_b_q);

endmodule

//--- src/dac_backend.sv
// dac output stage
module dac_backend #(
  parameter int DAT_W = 14 // converter resolution
) (
  input  logic                    adc_clk,
  input  logic                    arst_n_i,
  input  logic signed [DAT_W-1:0] level_a_i,
  input  logic signed [DAT_W-1:0] level_b_i,
  input  logic signed [DAT_W-1:0] offset_a_i,
  input  logic signed [DAT_W-1:0] offset_b_i,
  output logic signed [DAT_W-1:0] sat_a_o,     // to loopback, before the register
  output logic signed [DAT_W-1:0] sat_b_o,
  output logic        [DAT_W-1:0] dac_dat_a_o, // inverted offset binary
  output logic        [DAT_W-1:0] dac_dat_b_o,
  output logic                    dac_rst_o    // high in reset
);

  logic signed [DAT_W:0] sum_a, sum_b;       // one guard bit
  logic [DAT_W-1:0]      dat_a_q, dat_b_q;   // output register
  logic                  rst_q;

  // clip to full scale when the guard bit disagrees with the msb
  function automatic logic signed [DAT_W-1:0] saturate(input logic signed [DAT_W:0] s);
    if (s[DAT_W] != s[DAT_W-1])
      return {s[DAT_W], {(DAT_W-1){~s[DAT_W]}}}; // 0x1fff or 0x2000
    else
      return s[DAT_W-1:0];
  endfunction

  ////////////////////////////////////////////////////////////
  // sum and saturate
  ////////////////////////////////////////////////////////////

  assign sum_a = {level_a_i[DAT_W-1], level_a_i} + {offset_a_i[DAT_W-1], offset_a_i};
  assign sum_b = {level_b_i[DAT_W-1], level_b_i} + {offset_b_i[DAT_W-1], offset_b_i};

  assign sat_a_o = saturate(sum_a);
  assign sat_b_o = saturate(sum_b);

  // register, back to offset binary with negative slope
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dat_a_q <= {1'b0, {(DAT_W-1){1'b1}}}; // conversion of zero
      dat_b_q <= {1'b0, {(DAT_W-1){1'b1}}};
      rst_q   <= 1'b1;                       // hold dac in reset
    end
    else
    begin
      dat_a_q <= {sat_a_o[DAT_W-1], ~sat_a_o[DAT_W-2:0]};
      dat_b_q <= {sat_b_o[DAT_W-1], ~sat_b_o[DAT_W-2:0]};
      rst_q   <= 1'b0; // released at first edge
    end
  end

  assign dac_dat_a_o = dat_a_q;
  assign dac_dat_b_o = dat_b_q;
  assign dac_rst_o   = rst_q;

endmodule

//--- src/analog_top.sv
// analog core top level
module analog_top
  import rp_pkg::*;
#(
  parameter int DAT_W = $bits(sample_t) // converter resolution, 14
) (
  input  logic                  adc_clk,
  input  logic                  arst_n_i,
  // system bus
  input  logic [BUS_AW-1:0]     sys_addr_i,
  input  logic [BUS_DW-1:0]     sys_wdata_i,
  input  logic [BUS_DW/8-1:0]   sys_sel_i,   // byte selects, full words only
  input  logic                  sys_wen_i,
  input  logic                  sys_ren_i,
  output logic [BUS_DW-1:0]     sys_rdata_o,
  output logic                  sys_err_o,
  output logic                  sys_ack_o,
  // converters
  input  logic [DAT_W-1:0]      adc_dat_a_i, // raw codes
  input  logic [DAT_W-1:0]      adc_dat_b_i,
  output logic [DAT_W-1:0]      dac_dat_a_o,
  output logic [DAT_W-1:0]      dac_dat_b_o,
  output logic                  dac_rst_o,
  // board
  output logic [LED_W-1:0]      led_o
);

  logic              hk_wen, hk_ren, hk_ack;    // region 0
  logic [BUS_DW-1:0] hk_rdata;
  logic              ana_wen, ana_ren, ana_ack; // region 1
  logic [BUS_DW-1:0] ana_rdata;
  logic              digital_loop;

  logic signed [DAT_W-1:0] adc_a, adc_b;       // converted samples
  logic signed [DAT_W-1:0] level_a, level_b;
  logic signed [DAT_W-1:0] offset_a, offset_b;
  logic signed [DAT_W-1:0] sat_a, sat_b;       // loopback source

  ////////////////////////////////////////////////////////////
  // bus fabric and register blocks
  ////////////////////////////////////////////////////////////

  sys_bus_decoder i_dec (
    .sys_addr_i  (sys_addr_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_err_o   (sys_err_o),
    .sys_ack_o   (sys_ack_o),
    .hk_rdata_i  (hk_rdata),
    .hk_ack_i    (hk_ack),
    .hk_wen_o    (hk_wen),
    .hk_ren_o    (hk_ren),
    .ana_rdata_i (ana_rdata),
    .ana_ack_i   (ana_ack),
    .ana_wen_o   (ana_wen),
    .ana_ren_o   (ana_ren)
  );

  housekeeping_regs i_hk (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .addr_i         (sys_addr_i[OFS_W-1:0]),
    .wdata_i        (sys_wdata_i),
    .wen_i          (hk_wen),
    .ren_i          (hk_ren),
    .rdata_o        (hk_rdata),
    .ack_o          (hk_ack),
    .led_o          (led_o),
    .digital_loop_o (digital_loop)
  );

  analog_regs i_ana (
    .adc_clk    (adc_clk),
    .arst_n_i   (arst_n_i),
    .addr_i     (sys_addr_i[OFS_W-1:0]),
    .wdata_i    (sys_wdata_i),
    .wen_i      (ana_wen),
    .ren_i      (ana_ren),
    .rdata_o    (ana_rdata),
    .ack_o      (ana_ack),
    .adc_a_i    (adc_a),
    .adc_b_i    (adc_b),
    .level_a_o  (level_a),
    .level_b_o  (level_b),
    .offset_a_o (offset_a),
    .offset_b_o (offset_b)
  );

  ////////////////////////////////////////////////////////////
  // converter paths
  ////////////////////////////////////////////////////////////

  adc_frontend #(.DAT_W(DAT_W)) i_adc (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .loop_a_i       (sat_a),
    .loop_b_i       (sat_b),
    .adc_a_o        (adc_a),
    .adc_b_o        (adc_b)
  );

  dac_backend #(.DAT_W(DAT_W)) i_dac (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .level_a_i   (level_a),
    .level_b_i   (level_b),
    .offset_a_i  (offset_a),
    .offset_b_i  (offset_b),
    .sat_a_o     (sat_a),
    .sat_b_o     (sat_b),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .dac_rst_o   (dac_rst_o)
  );

endmodule

//--- test/analog_tb.sv
// analog core testbench
module analog_tb
  import rp_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_CYCLES = 5000; // whole sequence runs well under 1500 cycles

  logic              adc_clk = 1'b0;
  logic              arst_n_i;
  logic [31:0]       sys_addr_i, sys_wdata_i, sys_rdata_o;
  logic [3:0]        sys_sel_i;
  logic              sys_wen_i, sys_ren_i, sys_err_o, sys_ack_o;
  logic [13:0]       adc_dat_a_i, adc_dat_b_i; // raw codes
  logic [13:0]       dac_dat_a_o, dac_dat_b_o;
  logic              dac_rst_o;
  logic [7:0]        led_o;

  logic [31:0]        lfsr = 32'h8450_88ad;
  logic signed [13:0] sp [4]; // model: level a, level b, offset a, offset b
  logic [7:0]         led_exp; // model of the led byte
  int errors, test_errors, tests_run, tests_failed, cycles;

  analog_top #(.DAT_W(14)) UUT (.*);

  always #4 adc_clk = ~adc_clk; // 8 ns period

  ////////////////////////////////////////////////////////////
  // bus and reset properties
  ////////////////////////////////////////////////////////////

  assert property (@(posedge adc_clk) !sys_err_o)
  else
  begin
    errors++;
    $display("error raised on the bus at time %0t", $time);
  end

  // once out of reset for a full cycle the dac stays released
  assert property (@(posedge adc_clk) disable iff (!arst_n_i) $past(arst_n_i) |-> !dac_rst_o)
  else
  begin
    errors++;
    $display("dac reset came back high at time %0t", $time);
  end

  ////////////////////////////////////////////////////////////
  // random numbers and reference model
  ////////////////////////////////////////////////////////////

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic signed [13:0] adc_model(input logic [13:0] code);
    return code ^ 14'h1FFF; // top bit kept
  endfunction

  function automatic logic signed [13:0] sat_model(input logic signed [13:0] a, b);
    int s;
    s = int'(a) + int'(b);
    if (s > 8191)
      s = 8191; // clip high
    else if (s < -8192)
      s = -8192;
    return 14'(s);
  endfunction

  function automatic logic [13:0] dac_model(input logic signed [13:0] v);
    return v ^ 14'h1FFF;
  endfunction

  function automatic logic [31:0] sext(input logic signed [13:0] v);
    return {{18{v[13]}}, v};
  endfunction

  function automatic logic [31:0] reg_addr(input int region, input logic [19:0] ofs);
    return {9'h0, 3'(region), ofs};
  endfunction

  ////////////////////////////////////////////////////////////
  // checks and bus tasks
  ////////////////////////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      errors++;
      $display("Mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_dac();
    check("dac_dat_a_o", 32'(dac_dat_a_o), 32'(dac_model(sat_model(sp[0], sp[2]))));
    check("dac_dat_b_o", 32'(dac_dat_b_o), 32'(dac_model(sat_model(sp[1], sp[3]))));
  endtask

  // one strobe cycle, then ack expected in the very next cycle
  task automatic bus_cycle(input logic wr, input logic [31:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    int waits;
    @(negedge adc_clk);
    sys_addr_i  = addr;
    sys_wdata_i = wdata;
    sys_wen_i   = wr;
    sys_ren_i   = !wr;
    @(negedge adc_clk);
    sys_wen_i = 1'b0;
    sys_ren_i = 1'b0;
    waits = 0;
    while (!sys_ack_o && waits < 4) // bounded wait
    begin
      @(negedge adc_clk);
      waits++;
    end
    assert (sys_ack_o && waits == 0)
    else
    begin
      errors++;
      $display("no acknowledge in the cycle after the strobe, address %h", addr);
    end
    rdata = sys_rdata_o; // stable mid-cycle
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] unused;
    bus_cycle(1'b1, addr, wdata, unused);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
    bus_cycle(1'b0, addr, 32'h0, rdata);
  endtask

  // write one set-point, dac follows two edges later
  task automatic write_setpoint(input int idx, input logic [31:0] wdata);
    logic [31:0] rd;
    bus_write(reg_addr(REGION_ANA, 20'(idx * 4)), wdata);
    sp[idx] = wdata[13:0];
    @(negedge adc_clk);
    check_dac();
    bus_read(reg_addr(REGION_ANA, 20'(idx * 4)), rd);
    check($sformatf("set-point %0d", idx), rd, sext(sp[idx]));
  endtask

  task automatic write_setpoints(input logic [31:0] la, lb, oa, ob);
    write_setpoint(0, la);
    write_setpoint(1, lb);
    write_setpoint(2, oa);
    write_setpoint(3, ob);
  endtask

  task automatic check_samples(input logic signed [13:0] exp_a, exp_b);
    logic [31:0] rd;
    bus_read(reg_addr(REGION_ANA, ANA_ADC_A_OFS), rd);
    check("adc sample a", rd, sext(exp_a));
    bus_read(reg_addr(REGION_ANA, ANA_ADC_B_OFS), rd);
    check("adc sample b", rd, sext(exp_b));
  endtask

  task automatic check_zero(input logic [31:0] addr);
    logic [31:0] rd;
    bus_read(addr, rd);
    check($sformatf("sys_rdata_o at %h", addr), rd, 32'h0);
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != test_errors)
      tests_failed++;
    $display("test %-10s %s", name, (errors == test_errors) ? "ok" : "FAILED");
    test_errors = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    logic [31:0] rd;
    arst_n_i    = 1'b0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_sel_i   = 4'hF; // full words
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    led_exp     = '0;
    errors      = 0;
    test_errors = 0;
    tests_run   = 0;
    tests_failed = 0;
    foreach (sp[i])
      sp[i] = '0;

    // reset: outputs idle, dac held
    repeat (2) @(negedge adc_clk);
    check("led_o", 32'(led_o), 32'h0);
    check("dac_rst_o", 32'(dac_rst_o), 32'h1);
    check_dac();
    repeat (3) @(negedge adc_clk); // 5 cycles in reset
    arst_n_i = 1'b1;
    @(negedge adc_clk);
    check("dac_rst_o", 32'(dac_rst_o), 32'h0); // first edge after release
    check("led_o", 32'(led_o), 32'h0);
    check_dac();
    end_test("reset");

    // housekeeping
    bus_read(reg_addr(REGION_HK, HK_ID_OFS), rd);
    check("id word", rd, HK_ID_VALUE);
    repeat (4)
    begin
      led_exp = 8'(rand_bits(8));
      bus_write(reg_addr(REGION_HK, HK_LED_OFS), {24'(rand_bits(24)), led_exp});
      check("led_o", 32'(led_o), 32'(led_exp));
      bus_read(reg_addr(REGION_HK, HK_LED_OFS), rd);
      check("led read-back", rd, 32'(led_exp));
    end
    for (int v = 1; v >= 0; v--)
    begin
      bus_write(reg_addr(REGION_HK, HK_LOOP_OFS), 32'(v));
      bus_read(reg_addr(REGION_HK, HK_LOOP_OFS), rd);
      check("loop bit", rd, 32'(v));
    end
    end_test("hk");

    // dac path, random then overflow both ways
    repeat (6)
      write_setpoints(rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32));
    write_setpoints(32'h1F00, 32'h1FFF, 32'h0400, 32'h0001); // above full scale
    write_setpoints(32'h2100, 32'h2000, 32'h3C00, 32'h3FFF); // below
    end_test("dac");

    // adc path, loopback off
    repeat (6)
    begin
      @(negedge adc_clk);
      adc_dat_a_i = 14'(rand_bits(14));
      adc_dat_b_i = 14'(rand_bits(14));
      repeat (3) @(negedge adc_clk); // codes held
      check_samples(adc_model(adc_dat_a_i), adc_model(adc_dat_b_i));
    end
    end_test("adc");

    // loopback, samples follow the saturated sum
    bus_write(reg_addr(REGION_HK, HK_LOOP_OFS), 32'h1);
    adc_dat_a_i = 14'(rand_bits(14));
    adc_dat_b_i = 14'(rand_bits(14));
    check_samples(sat_model(sp[0], sp[2]), sat_model(sp[1], sp[3]));
    write_setpoints(32'h1F00, 32'h0123, 32'h0400, 32'h3F00);
    check_samples(sat_model(sp[0], sp[2]), sat_model(sp[1], sp[3]));
    bus_write(reg_addr(REGION_HK, HK_LOOP_OFS), 32'h0);
    check_samples(adc_model(adc_dat_a_i), adc_model(adc_dat_b_i)); // pins again
    end_test("loopback");

    // unused regions and holes
    for (int r = 2; r < N_REGIONS; r++)
    begin
      check_zero(reg_addr(r, 20'(rand_bits(18) << 2)));
      bus_write(reg_addr(r, HK_LED_OFS), rand_bits(32));      // aliases must not hit
      bus_write(reg_addr(r, ANA_LEVEL_A_OFS), rand_bits(32));
    end
    bus_write(reg_addr(REGION_ANA, 20'h18), rand_bits(32));
    check("led_o", 32'(led_o), 32'(led_exp));
    check_dac();
    bus_read(reg_addr(REGION_ANA, ANA_LEVEL_A_OFS), rd);
    check("level a", rd, sext(sp[0]));
    check_zero(reg_addr(REGION_HK, 20'h0C));
    check_zero(reg_addr(REGION_HK, 20'h100));
    check_zero(reg_addr(REGION_ANA, 20'h18));
    check_zero(reg_addr(REGION_ANA, 20'h400));
    end_test("unused");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // watchdog
  initial
  begin
    cycles = 0;
    while (cycles < MAX_CYCLES)
    begin
      @(posedge adc_clk);
      cycles++;
    end
    $display("timeout, sequence still running after %0d cycles", cycles);
    $display("sim failed");
    $finish;
  end

endmodule

//--- flist.f
src/rp_pkg.sv
src/sys_bus_decoder.sv
src/housekeeping_regs.sv
src/analog_regs.sv
src/adc_frontend.sv
src/dac_backend.sv
src/analog_top.sv
test/analog_tb.sv

//--- Makefile
# Verilator build and run for the analog core testbench

VERILATOR ?= verilator
TOP       ?= analog_tb
FLAGS     ?= --assert -Wno-fatal
OBJ_DIR   ?= obj_dir
FLIST     ?= flist.f
SRCS      := $(wildcard src/*.sv) $(wildcard test/*.sv)

.PHONY: all build run clean

all: run

build: $(OBJ_DIR)/V$(TOP)

# rebuilt only when a source or the file list changes
$(OBJ_DIR)/V%: $(FLIST) $(SRCS)
	$(VERILATOR) --binary $(FLAGS) --top-module $* -f $(FLIST) --Mdir $(OBJ_DIR)

# status comes from the search for the pass line
run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)
